// ==== bench/conv_core_tb.sv ====
`timescale 1ns/1ns

module conv_core_tb;

    localparam int LAT_1X1  = conv_pkg::ACC_DELAY;
    localparam int LAT_CASC = 1 + conv_pkg::STEPS * (conv_pkg::ACC_DELAY - 1);
    localparam int TIMEOUT  = 400;
    localparam int OP_CFG   = 0;
    localparam int OP_BEATS = 1;
    localparam int OP_BUSY  = 2;
    localparam int OP_STALL = 3;
    localparam int NROWS    = 10;

    typedef logic [conv_pkg::STEPS-1:0][conv_pkg::WGT_W-1:0] wvec_t;

    typedef struct packed {
        logic [31:0]                                 stamp;
        logic                                        is_1x1;
        logic                                        last;
        logic [conv_pkg::USER_W-1:0]                 user;
        logic [conv_pkg::STEPS-1:0][conv_pkg::ACC_W-1:0] acc;
    } expect_t;

    typedef struct {
        string name;
        int    op;
        logic  is_1x1;
        wvec_t weights;
        int    beats;
    } row_t;

    logic aclk, arst_n, aclken, in_valid, in_last, cfg_load, cfg_is_1x1;
    logic busy, cfg_err, frame_done;
    logic [conv_pkg::USER_W-1:0] in_user;
    logic [conv_pkg::STEPS-1:0][conv_pkg::PIX_W-1:0] in_pix;
    wvec_t cfg_weights;
    conv_pkg::acc_lane_t [conv_pkg::STEPS-1:0] out_lanes, snap;

    row_t    rows [NROWS];
    expect_t exp_q [$];
    logic    m_1x1 = 1'b1;
    wvec_t   m_w = '0;
    logic    last_en = 1'b1;
    logic    abort = 1'b0;
    int      seed = 51975;
    int      val_errs = 0, other_errs = 0, frames_exp = 0, frames_got = 0;
    int      cfg_err_exp = 0, cfg_err_got = 0;
    int      ecnt;
    string   cur_name = "reset_check";

    tb_clock u_clk (.aclk(aclk), .arst_n(arst_n));

    conv_core dut (
        .aclk(aclk), .aclken(aclken), .arst_n(arst_n),
        .in_valid(in_valid), .in_last(in_last), .in_user(in_user), .in_pix(in_pix),
        .cfg_load(cfg_load), .cfg_is_1x1(cfg_is_1x1), .cfg_weights(cfg_weights),
        .out_lanes(out_lanes), .busy(busy), .cfg_err(cfg_err), .frame_done(frame_done)
    );

    // Counts enabled edges since reset to time each result
    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ecnt <= 0;
        end else if (aclken) begin
            ecnt <= ecnt + 1;
        end
    end

    // A value seen at the falling edge is consumed by the next enabled rising edge
    always @(negedge aclk) begin
        expect_t             e;
        conv_pkg::acc_lane_t x;
        int                  lat;
        if (arst_n) begin
            if (!last_en && out_lanes != snap) begin
                $display("outputs changed while aclken was low in %s", cur_name);
                other_errs++;
            end
            // Every queued entry is a beat taken and not yet consumed at the tail
            if (busy !== (exp_q.size() != 0)) begin
                $display("busy does not match the beats in flight in %s", cur_name);
                other_errs++;
            end
            if (aclken && in_valid) begin
                e.stamp  = ecnt + 1;
                e.is_1x1 = m_1x1;
                e.last   = in_last;
                e.user   = in_user;
                e.acc    = '0;
                for (int i = 0; i < conv_pkg::STEPS; i++) begin
                    if (m_1x1) begin
                        e.acc[i] = in_pix[i] * m_w[i];
                    end else begin
                        e.acc[conv_pkg::STEPS-1] += in_pix[i] * m_w[i];
                    end
                end
                exp_q.push_back(e);
                if (in_last) frames_exp++;
            end
            if (aclken) begin
                if (frame_done) frames_got++;
                if (cfg_err) cfg_err_got++;
                if (out_lanes[conv_pkg::STEPS-1].side.valid) begin
                    if (exp_q.size() == 0) begin
                        $display("unexpected result on the final lane in %s", cur_name);
                        other_errs++;
                    end else begin
                        e = exp_q.pop_front();
                        lat = e.is_1x1 ? LAT_1X1 : LAT_CASC;
                        if (ecnt - int'(e.stamp) != lat - 1) begin
                            $display("ERR %s latency expected %0d actual %0d",
                                     cur_name, lat, ecnt - int'(e.stamp) + 1);
                            val_errs++;
                        end
                        for (int i = 0; i < conv_pkg::STEPS; i++) begin
                            x = '{side: '{valid: 1'b1, last: e.last, user: e.user},
                                  acc: e.acc[i]};
                            if (!e.is_1x1 && i != conv_pkg::STEPS - 1) begin
                                // Partial-sum lanes only promise a low valid
                                if (out_lanes[i].side.valid !== 1'b0) begin
                                    $display("ERR %s lane %0d valid expected 0 actual %b",
                                             cur_name, i, out_lanes[i].side.valid);
                                    val_errs++;
                                end
                            end else if (out_lanes[i] != x) begin
                                $display("ERR %s lane %0d expected %h actual %h",
                                         cur_name, i, x, out_lanes[i]);
                                val_errs++;
                            end
                        end
                    end
                end else begin
                    for (int i = 0; i < conv_pkg::STEPS - 1; i++) begin
                        if (out_lanes[i].side.valid) begin
                            $display("lane %0d valid without a final lane result in %s",
                                     i, cur_name);
                            other_errs++;
                        end
                    end
                end
            end
        end
        snap    = out_lanes;
        last_en = aclken;
    end

    task automatic wait_reset();
        int t;
        t = 0;
        while (!arst_n && t < 50) begin
            @(posedge aclk);
            t++;
        end
        if (!arst_n) begin
            $display("reset never released");
            other_errs++;
            abort = 1'b1;
        end
    endtask

    task automatic load_cfg(input logic is1, input wvec_t w);
        @(posedge aclk);
        aclken      <= 1'b1;
        cfg_load    <= 1'b1;
        cfg_is_1x1  <= is1;
        cfg_weights <= w;
        @(posedge aclk);
        cfg_load <= 1'b0;
    endtask

    task automatic send_beats(input int n, input logic [15:0] pat);
        logic [31:0] r;
        logic        en;
        int          idx;
        idx = 0;
        for (int k = 0; k < n; k++) begin
            r  = $random(seed);
            en = 1'b0;
            // Hold the beat until an enabled edge takes it
            while (!en) begin
                @(posedge aclk);
                in_valid <= 1'b1;
                in_last  <= (k == n - 1) || (r[1] && r[0]);
                in_user  <= r[31:28];
                in_pix   <= r[27:4];
                en = pat[idx % 16];
                aclken <= en;
                idx++;
            end
        end
        @(posedge aclk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        aclken   <= pat[idx % 16];
    endtask

    task automatic drain(input logic [15:0] pat);
        int t;
        t = 0;
        while (t < TIMEOUT) begin
            @(negedge aclk);
            if (!busy && exp_q.size() == 0) break;
            @(posedge aclk);
            aclken <= pat[t % 16];
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("timeout waiting for the pipeline to drain in %s", cur_name);
            other_errs++;
            abort = 1'b1;
        end
        // Flush stale skew entries before any mode change
        repeat (LAT_CASC + 2) begin
            @(posedge aclk);
            aclken <= 1'b1;
        end
    endtask

    initial begin
        logic [15:0] pat;
        rows[0] = '{"cfg_1x1",      OP_CFG,   1'b1, {8'd7, 8'd5, 8'd3},       0};
        rows[1] = '{"beats_1x1",    OP_BEATS, 1'b1, '0,                        8};
        rows[2] = '{"cfg_casc",     OP_CFG,   1'b0, {8'd250, 8'd9, 8'd2},     0};
        rows[3] = '{"beats_casc",   OP_BEATS, 1'b0, '0,                        8};
        rows[4] = '{"cfg_busy",     OP_BUSY,  1'b1, {8'd1, 8'd1, 8'd1},       4};
        rows[5] = '{"after_reject", OP_BEATS, 1'b0, '0,                        5};
        rows[6] = '{"cfg_1x1_b",    OP_CFG,   1'b1, {8'd13, 8'd200, 8'd11},   0};
        rows[7] = '{"stall_1x1",    OP_STALL, 1'b1, '0,                       10};
        rows[8] = '{"cfg_casc_b",   OP_CFG,   1'b0, {8'd255, 8'd255, 8'd255}, 0};
        rows[9] = '{"stall_casc",   OP_STALL, 1'b0, '0,                       10};
        aclken = 1'b1;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = '0;
        in_pix = '0;
        cfg_load = 1'b0;
        cfg_is_1x1 = 1'b0;
        cfg_weights = '0;
        wait_reset();
        @(negedge aclk);
        for (int i = 0; i < conv_pkg::STEPS; i++) begin
            if (out_lanes[i].side.valid !== 1'b0) begin
                $display("ERR reset_check valid expected 0 actual %b", out_lanes[i].side.valid);
                val_errs++;
            end
        end
        if ({busy, cfg_err, frame_done} !== 3'b000) begin
            $display("ERR reset_check status expected 000 actual %b",
                     {busy, cfg_err, frame_done});
            val_errs++;
        end
        for (int r = 0; r < NROWS && !abort; r++) begin
            cur_name = rows[r].name;
            pat = (rows[r].op == OP_STALL) ? ($random(seed) | 16'h0001) : 16'hffff;
            case (rows[r].op)
                OP_CFG: begin
                    load_cfg(rows[r].is_1x1, rows[r].weights);
                    m_1x1 = rows[r].is_1x1;
                    m_w   = rows[r].weights;
                end
                OP_BUSY: begin
                    send_beats(rows[r].beats, pat);
                    // Pipeline is still full, so this load must bounce
                    load_cfg(rows[r].is_1x1, rows[r].weights);
                    cfg_err_exp++;
                    drain(pat);
                end
                default: begin
                    send_beats(rows[r].beats, pat);
                    drain(pat);
                end
            endcase
        end
        repeat (2) @(negedge aclk);
        if (frames_got != frames_exp) begin
            $display("ERR frame_done expected %0d actual %0d", frames_exp, frames_got);
            val_errs++;
        end
        if (cfg_err_got != cfg_err_exp) begin
            $display("ERR cfg_err expected %0d actual %0d", cfg_err_exp, cfg_err_got);
            val_errs++;
        end
        if (busy || exp_q.size() != 0) begin
            $display("busy still high or results missing at the end");
            other_errs++;
        end
        $display("value errors %0d, other errors %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic aclk,
    output logic arst_n
);

    // 20 ns period
    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;
    end

endmodule

// ==== conv_core.f ====
rtl/conv_pkg.sv
rtl/n_delay.sv
rtl/step_buffer.sv
rtl/mac_array.sv
rtl/conv_ctrl.sv
rtl/conv_core.sv
bench/tb_clock.sv
bench/conv_core_tb.sv

// ==== rtl/conv_core.sv ====
`timescale 1ns/1ns

module conv_core (
    input  logic                                            aclk,
    input  logic                                            aclken,
    input  logic                                            arst_n,
    input  logic                                            in_valid,
    input  logic                                            in_last,
    input  logic [conv_pkg::USER_W-1:0]                     in_user,
    input  logic [conv_pkg::STEPS-1:0][conv_pkg::PIX_W-1:0] in_pix,
    input  logic                                            cfg_load,
    input  logic                                            cfg_is_1x1,
    input  logic [conv_pkg::STEPS-1:0][conv_pkg::WGT_W-1:0] cfg_weights,
    output conv_pkg::acc_lane_t [conv_pkg::STEPS-1:0]       out_lanes,
    output logic                                            busy,
    output logic                                            cfg_err,
    output logic                                            frame_done
);

    conv_pkg::cfg_t                            cfg;
    conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] raw_lanes;
    conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] skew_lanes;

    // Every lane carries the beat's sideband along with its pixel
    for (genvar i = 0; i < conv_pkg::STEPS; i++) begin : g_pack
        assign raw_lanes[i] = '{
            side: '{valid: in_valid, last: in_last, user: in_user},
            pix:  in_pix[i]
        };
    end

    conv_ctrl u_ctrl (
        .aclk        (aclk),
        .aclken      (aclken),
        .arst_n      (arst_n),
        .cfg_load    (cfg_load),
        .cfg_is_1x1  (cfg_is_1x1),
        .cfg_weights (cfg_weights),
        .in_valid    (in_valid),
        .in_last     (in_last),
        .tail_valid  (out_lanes[conv_pkg::STEPS-1].side.valid),
        .tail_last   (out_lanes[conv_pkg::STEPS-1].side.last),
        .cfg         (cfg),
        .busy        (busy),
        .cfg_err     (cfg_err),
        .frame_done  (frame_done)
    );

    step_buffer u_step (
        .aclk      (aclk),
        .aclken    (aclken),
        .arst_n    (arst_n),
        .is_1x1    (cfg.is_1x1),
        .lanes_in  (raw_lanes),
        .lanes_out (skew_lanes)
    );

    mac_array u_mac (
        .aclk      (aclk),
        .aclken    (aclken),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .lanes_in  (skew_lanes),
        .lanes_out (out_lanes)
    );

endmodule

// ==== rtl/conv_ctrl.sv ====
`timescale 1ns/1ns

module conv_ctrl (
    input  logic                                                aclk,
    input  logic                                                aclken,
    input  logic                                                arst_n,
    input  logic                                                cfg_load,
    input  logic                                                cfg_is_1x1,
    input  logic [conv_pkg::STEPS-1:0][conv_pkg::WGT_W-1:0]     cfg_weights,
    input  logic                                                in_valid,
    input  logic                                                in_last,
    input  logic                                                tail_valid,
    input  logic                                                tail_last,
    output conv_pkg::cfg_t                                      cfg,
    output logic                                                busy,
    output logic                                                cfg_err,
    output logic                                                frame_done
);

    logic [conv_pkg::CNT_W-1:0] beats_q;
    logic [conv_pkg::CNT_W-1:0] frames_q;
    logic                       frame_in;
    logic                       frame_out;
    logic                       cfg_ok;

    assign busy = (beats_q != '0);

    // A load must not overlap any beat, queued or arriving
    assign cfg_ok = cfg_load && !busy && !in_valid;

    assign frame_in  = in_valid && in_last;
    assign frame_out = tail_valid && tail_last && (frames_q != '0);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            beats_q    <= '0;
            frames_q   <= '0;
            cfg        <= '{is_1x1: 1'b1, weights: '0};
            cfg_err    <= 1'b0;
            frame_done <= 1'b0;
        end else if (aclken) begin
            case ({in_valid, tail_valid})
                2'b10:   beats_q <= beats_q + 1'b1;
                2'b01:   beats_q <= beats_q - 1'b1;
                default: beats_q <= beats_q;
            endcase

            // Frames still open in the pipe
            case ({frame_in, frame_out})
                2'b10:   frames_q <= frames_q + 1'b1;
                2'b01:   frames_q <= frames_q - 1'b1;
                default: frames_q <= frames_q;
            endcase

            if (cfg_ok) begin
                cfg <= '{is_1x1: cfg_is_1x1, weights: cfg_weights};
            end

            cfg_err    <= cfg_load && !cfg_ok;
            frame_done <= frame_out;
        end
    end

endmodule

// ==== rtl/conv_pkg.sv ====
package conv_pkg;

    // Lanes, one per kernel tap
    localparam int STEPS = 3;

    // A lane result shows up ACC_DELAY-1 cycles after its operands
    localparam int ACC_DELAY = 4;

    localparam int PIX_W  = 8;
    localparam int WGT_W  = 8;
    localparam int ACC_W  = 18;
    localparam int USER_W = 4;

    // Deepest path through the slice, which also bounds the beats in flight
    localparam int MAX_INFLIGHT = 1 + STEPS * (ACC_DELAY - 1);
    localparam int CNT_W        = $clog2(MAX_INFLIGHT + 1);

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [USER_W-1:0] user;
    } side_t;

    // One lane entering the skew
    typedef struct packed {
        side_t            side;
        logic [PIX_W-1:0] pix;
    } pix_lane_t;

    // One lane leaving the MAC array
    typedef struct packed {
        side_t            side;
        logic [ACC_W-1:0] acc;
    } acc_lane_t;

    typedef struct packed {
        logic                        is_1x1;
        logic [STEPS-1:0][WGT_W-1:0] weights;
    } cfg_t;

endpackage

// ==== rtl/mac_array.sv ====
`timescale 1ns/1ns

module mac_array (
    input  logic                                      aclk,
    input  logic                                      aclken,
    input  logic                                      arst_n,
    input  conv_pkg::cfg_t                            cfg,
    input  conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] lanes_in,
    output conv_pkg::acc_lane_t [conv_pkg::STEPS-1:0] lanes_out
);

    logic [conv_pkg::ACC_W-1:0] acc_d  [conv_pkg::STEPS];
    logic [conv_pkg::ACC_W-1:0] acc_q  [conv_pkg::STEPS];
    conv_pkg::side_t            side_q [conv_pkg::STEPS];

    for (genvar i = 0; i < conv_pkg::STEPS; i++) begin : g_lane
        logic [conv_pkg::ACC_W-1:0] prod;
        logic [conv_pkg::ACC_W-1:0] casc;
        conv_pkg::side_t            side_o;

        // Product is formed at full accumulator width
        assign prod = lanes_in[i].pix * cfg.weights[i];

        if (i == 0) begin : g_head
            assign casc = '0;
        end else begin : g_chain
            // Previous lane's sum lands here in the same cycle as this lane's pixel
            assign casc = cfg.is_1x1 ? '0 : acc_q[i-1];
        end

        assign acc_d[i] = prod + casc;

        // First stage of each delay registers the sum, the rest pipeline it
        n_delay #(
            .N (conv_pkg::ACC_DELAY - 1),
            .T (logic [conv_pkg::ACC_W-1:0])
        ) u_acc (
            .aclk   (aclk),
            .aclken (aclken),
            .arst_n (arst_n),
            .d      (acc_d[i]),
            .q      (acc_q[i])
        );

        n_delay #(
            .N (conv_pkg::ACC_DELAY - 1),
            .T (conv_pkg::side_t)
        ) u_side (
            .aclk   (aclk),
            .aclken (aclken),
            .arst_n (arst_n),
            .d      (lanes_in[i].side),
            .q      (side_q[i])
        );

        // Only the tail lane holds a complete dot product in cascade mode
        always_comb begin
            side_o = side_q[i];
            if (!cfg.is_1x1 && (i != conv_pkg::STEPS - 1)) begin
                side_o.valid = 1'b0;
            end
        end

        assign lanes_out[i] = '{side: side_o, acc: acc_q[i]};
    end

endmodule

// ==== rtl/n_delay.sv ====
`timescale 1ns/1ns

module n_delay #(
    parameter int  N = 1,
    parameter type T = logic
) (
    input  logic aclk,
    input  logic aclken,
    input  logic arst_n,
    input  T     d,
    output T     q
);

    T stage [N];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < N; k++) begin
                stage[k] <= '0;
            end
        end else if (aclken) begin
            stage[0] <= d;
            // Shift towards the tail
            for (int k = 1; k < N; k++) begin
                stage[k] <= stage[k-1];
            end
        end
    end

    assign q = stage[N-1];

endmodule

// ==== rtl/step_buffer.sv ====
`timescale 1ns/1ns

module step_buffer (
    input  logic                                      aclk,
    input  logic                                      aclken,
    input  logic                                      arst_n,
    input  logic                                      is_1x1,
    input  conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] lanes_in,
    output conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] lanes_out
);

    conv_pkg::pix_lane_t [conv_pkg::STEPS-1:1] skew_q;
    conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] hold_d;
    conv_pkg::pix_lane_t [conv_pkg::STEPS-1:0] hold_q;

    // Lane 0 starts the cascade and needs no skew
    assign hold_d[0] = lanes_in[0];

    for (genvar i = 1; i < conv_pkg::STEPS; i++) begin : g_skew
        // Lane i waits for i partial sums to ripple through
        n_delay #(
            .N (i * (conv_pkg::ACC_DELAY - 1)),
            .T (conv_pkg::pix_lane_t)
        ) u_skew (
            .aclk   (aclk),
            .aclken (aclken),
            .arst_n (arst_n),
            .d      (lanes_in[i]),
            .q      (skew_q[i])
        );

        assign hold_d[i] = is_1x1 ? lanes_in[i] : skew_q[i];
    end

    // Hold stage on every lane keeps all paths one cycle longer
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            hold_q <= '0;
        end else if (aclken) begin
            hold_q <= hold_d;
        end
    end

    assign lanes_out = hold_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the conv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module conv_core_tb \
    -f conv_core.f -o conv_sim \
    && ./obj_dir/conv_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

grep -q '\*\*\* PASSED \*\*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
